//--- files.f
common/hub_pkg.sv
common/wb_pkg.sv
src/rx_buffer_bank.sv
readout/rx_pending_decoder.sv
readout/rx_readdata_latch.sv
readout/rx_wb_result.sv
src/can_rx_hub.sv
test/clock_gen.sv
test/can_rx_hub_asserts.sv
test/tb_can_rx_hub.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the CAN hub testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_can_rx_hub -Mdir "$build_dir" -f files.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

# bound assertions keep running so the testbench can report them
"./$build_dir/Vtb_can_rx_hub" +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Simulation failed" "$log"; then
   echo "run_sim: FAIL"
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "run_sim: simulator exited with status $status"
   exit 1
fi
echo "run_sim: PASS"
exit 0

//--- test/tb_can_rx_hub.sv
`default_nettype none

module tb_can_rx_hub
   import hub_pkg::*;
   import wb_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int max_cycles = 4000;

   logic      clock;
   logic      reset;
   rx_write_t rx_write;
   wb_req_t   wb_req;
   wb_rsp_t   wb_rsp;
   logic      irq_can_rec;
   int        cycles = 0;

   // reference model of the hub
   bus_mask_t                model_pending;
   rx_word_t [num_buses-1:0] model_words;
   bus_idx_t                 model_last;  // last granted bus
   logic                     model_overrun;
   logic                     model_held;
   rx_word_t                 model_held_word;

   clock_gen u_clock_gen (.clock(clock));

   can_rx_hub u_can_rx_hub (
      .clock       (clock),
      .reset       (reset),
      .rx_write    (rx_write),
      .wb_req      (wb_req),
      .wb_rsp      (wb_rsp),
      .irq_can_rec (irq_can_rec)
   );

   always @(posedge clock) begin
      cycles <= cycles + 1;
      if (u_can_rx_hub.u_can_rx_hub_asserts.failed) begin
         $display("A bound protocol assertion failed at %0t ns", $time);
         $display("Simulation failed");
         $fatal(1, "protocol assertion");
      end else if (cycles >= max_cycles) begin
         $display("Timeout: no finish after %0d cycles", cycles);
         $display("Simulation failed");
         $fatal(1, "timeout");
      end
   end

   task automatic check_value(input string what, input logic [15:0] got,
                              input logic [15:0] exp);
      assert (got === exp) else begin
         $display("ERROR at %0t ns: %s is 0x%04h, expected 0x%04h", $time, what, got, exp);
         $display("Simulation failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic apply_reset();
      @(posedge clock);
      #2 reset = 1'b1;
      repeat (10) @(posedge clock);
      #2 reset = 1'b0;
      model_pending = '0;
      model_overrun = 1'b0;
      model_held    = 1'b0;
      model_last    = bus_idx_t'(num_buses - 1);  // next search from bus 0
   endtask

   task automatic write_can(input bus_idx_t bus, input rx_word_t data);
      @(posedge clock);
      #2 rx_write = '{strobe: 1'b1, bus: bus, data: data};
      if (model_pending[bus]) model_overrun = 1'b1;
      model_pending[bus] = 1'b1;
      model_words[bus]   = data;
      @(posedge clock);
      #2 rx_write = '0;
   endtask

   task automatic wb_access(input logic we, input wb_adr_t adr, input wb_dat_t dat,
                            output wb_dat_t data);
      @(posedge clock);
      #2 wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
      do @(posedge clock); while (!wb_rsp.ack);
      data = wb_rsp.dat;
      #2 wb_req = '0;
   endtask

   function automatic bus_idx_t predict_bus();
      bus_idx_t b;
      b = model_last;
      repeat (num_buses) begin
         b = b + 1'b1;
         if (model_pending[b]) return b;
      end
      return b;
   endfunction

   task automatic check_status();
      wb_dat_t data;
      wb_dat_t exp;
      exp = {model_held, model_overrun, 9'b0, model_held ? model_last : bus_idx_t'(0)};
      wb_access(1'b0, addr_status, '0, data);
      check_value("status register", data, exp);
      model_overrun = 1'b0;  // cleared by the read
   endtask

   task automatic await_message();
      bus_idx_t exp_bus;
      exp_bus = predict_bus();
      while (!irq_can_rec) @(posedge clock);
      model_pending[exp_bus] = 1'b0;
      model_last      = exp_bus;
      model_held      = 1'b1;
      model_held_word = model_words[exp_bus];
      check_status();
   endtask

   task automatic read_message();
      wb_dat_t data;
      wb_access(1'b0, addr_data, '0, data);
      check_value("data register", data, model_held ? model_held_word : 16'h0000);
      model_held = 1'b0;
      repeat (2) @(posedge clock);
      check_value("irq_can_rec after data read", 16'(irq_can_rec), 16'h0000);
   endtask

   task automatic expect_quiet(input int watch);
      repeat (watch) begin
         @(posedge clock);
         check_value("irq_can_rec while idle", 16'(irq_can_rec), 16'h0000);
      end
   endtask

   initial begin
      bus_idx_t b;
      wb_dat_t  data;
      void'($urandom(85818));
      reset    = 1'b1;
      rx_write = '0;
      wb_req   = '0;
      apply_reset();

      // single message, host writes leave the held word alone
      write_can(bus_idx_t'($urandom_range(31)), rx_word_t'($urandom));
      await_message();
      wb_access(1'b1, addr_data, 16'hbeef, data);
      wb_access(1'b1, addr_status, 16'hffff, data);
      check_status();
      read_message();

      // data read with nothing held
      read_message();
      expect_quiet(6);

      // held word blocks the burst, order wraps past bus 31
      write_can(5'd30, rx_word_t'($urandom));
      await_message();
      write_can(5'd31, rx_word_t'($urandom));
      write_can(5'd0, rx_word_t'($urandom));
      write_can(5'd2, rx_word_t'($urandom));
      repeat (4) write_can(bus_idx_t'($urandom_range(31)), rx_word_t'($urandom));
      read_message();
      while (model_pending != '0) begin
         await_message();
         read_message();
      end
      expect_quiet(8);  // nothing duplicated

      // overrun on a slot written twice under back-pressure
      b = bus_idx_t'($urandom_range(31));
      write_can(b, rx_word_t'($urandom));
      await_message();
      write_can(b + 5'd7, rx_word_t'($urandom));
      write_can(b + 5'd7, rx_word_t'($urandom));
      read_message();
      await_message();
      check_status();
      read_message();

      // reset with one word held and one pending
      write_can(5'd9, rx_word_t'($urandom));
      await_message();
      write_can(5'd12, rx_word_t'($urandom));
      apply_reset();
      check_status();
      read_message();
      expect_quiet(8);
      write_can(5'd20, rx_word_t'($urandom));
      await_message();
      read_message();
      expect_quiet(4);

      if (u_can_rx_hub.u_can_rx_hub_asserts.failed) begin
         $display("Simulation failed");
         $fatal(1, "protocol assertion");
      end else begin
         $display("Simulation passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- test/can_rx_hub_asserts.sv
`default_nettype none

module can_rx_hub_asserts
   import hub_pkg::*;
   import wb_pkg::*;
(
   input logic    clock,
   input logic    reset,
   input wb_req_t wb_req,
   input wb_rsp_t wb_rsp,
   input logic    irq_can_rec,
   input grant_t  grant,
   input logic    held
);
   timeunit 1ns;
   timeprecision 1ps;

   logic ack_twice = 1'b0;
   logic ack_orphan = 1'b0;
   logic irq_in_reset = 1'b0;
   logic grant_busy = 1'b0;
   logic failed;

   assign failed = ack_twice | ack_orphan | irq_in_reset | grant_busy;  // seen by the testbench

   ack_single: assert property (@(posedge clock) disable iff (reset)
      wb_rsp.ack |=> !wb_rsp.ack)
      else begin
         $error("ack high in two consecutive cycles");
         ack_twice = 1'b1;
      end

   // ack only answers a strobed cycle
   ack_follows_stb: assert property (@(posedge clock) disable iff (reset)
      wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
      else begin
         $error("ack without a preceding cyc and stb cycle");
         ack_orphan = 1'b1;
      end

   irq_low_reset: assert property (@(posedge clock)
      $past(reset) |-> !irq_can_rec)
      else begin
         $error("irq_can_rec high in or right after reset");
         irq_in_reset = 1'b1;
      end

   grant_when_free: assert property (@(posedge clock) disable iff (reset)
      grant.valid |-> !held)
      else begin
         $error("grant issued while the holding register is full");
         grant_busy = 1'b1;
      end

endmodule

bind can_rx_hub can_rx_hub_asserts u_can_rx_hub_asserts (
   .clock(clock), .reset(reset), .wb_req(wb_req), .wb_rsp(wb_rsp),
   .irq_can_rec(irq_can_rec), .grant(grant), .held(held)
);

`default_nettype wire

//--- test/clock_gen.sv
`default_nettype none

module clock_gen (
   output logic clock
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int half_period = 20;  // 40 ns period

   initial begin
      clock = 1'b0;
      forever #half_period clock = ~clock;
   end

endmodule

`default_nettype wire

//--- src/can_rx_hub.sv
`default_nettype none

module can_rx_hub
   import hub_pkg::*;
   import wb_pkg::*;
(
   input  logic      clock,
   input  logic      reset,
   input  rx_write_t rx_write,
   input  wb_req_t   wb_req,
   output wb_rsp_t   wb_rsp,
   output logic      irq_can_rec
);

   bus_mask_t                pending;
   bus_mask_t                clear;
   rx_word_t [num_buses-1:0] words;
   logic                     overrun;
   logic                     overrun_clear;
   grant_t                   grant;
   logic                     held;
   bus_idx_t                 held_bus;
   rx_word_t                 held_word;
   logic                     hold_release;

   rx_buffer_bank u_rx_buffer_bank (
      .clock         (clock),
      .reset         (reset),
      .rx_write      (rx_write),
      .clear         (clear),
      .overrun_clear (overrun_clear),
      .pending       (pending),
      .words         (words),
      .overrun       (overrun)
   );

   rx_pending_decoder u_rx_pending_decoder (
      .clock   (clock),
      .reset   (reset),
      .pending (pending),
      .held    (held),
      .grant   (grant)
   );

   rx_readdata_latch u_rx_readdata_latch (
      .clock        (clock),
      .reset        (reset),
      .grant        (grant),
      .words        (words),
      .hold_release (hold_release),
      .clear        (clear),
      .held         (held),
      .held_bus     (held_bus),
      .held_word    (held_word),
      .irq_can_rec  (irq_can_rec)
   );

   // host register port
   rx_wb_result u_rx_wb_result (
      .clock         (clock),
      .reset         (reset),
      .wb_req        (wb_req),
      .wb_rsp        (wb_rsp),
      .held          (held),
      .held_bus      (held_bus),
      .held_word     (held_word),
      .overrun       (overrun),
      .hold_release  (hold_release),
      .overrun_clear (overrun_clear)
   );

endmodule

`default_nettype wire

//--- readout/rx_wb_result.sv
`default_nettype none

module rx_wb_result
   import hub_pkg::*;
   import wb_pkg::*;
(
   input  logic     clock,
   input  logic     reset,
   input  wb_req_t  wb_req,
   output wb_rsp_t  wb_rsp,
   input  logic     held,
   input  bus_idx_t held_bus,
   input  rx_word_t held_word,
   input  logic     overrun,
   output logic     hold_release,
   output logic     overrun_clear
);

   logic    ack;
   logic    access;
   logic    rd_status;
   logic    rd_data;
   wb_dat_t status_word;
   wb_dat_t read_value;
   wb_dat_t dat_q;

   // one ack per access even if stb stays high through ack
   assign access    = wb_req.cyc && wb_req.stb && !ack;
   assign rd_status = access && !wb_req.we && (wb_req.adr == addr_status);
   assign rd_data   = access && !wb_req.we && (wb_req.adr == addr_data);

   always_comb begin
      status_word     = '0;
      status_word[15] = held;
      status_word[14] = overrun;
      status_word[4:0] = held ? held_bus : '0;  // no stale bus number
   end

   always_comb begin
      read_value = '0;
      if (!wb_req.we) begin
         case (wb_req.adr)
            addr_status: read_value = status_word;
            addr_data:   read_value = held ? held_word : '0;
            default:     read_value = '0;
         endcase
      end
   end

   // control pulses, all aligned with ack
   always_ff @(posedge clock) begin
      if (reset) begin
         ack           <= 1'b0;
         hold_release  <= 1'b0;
         overrun_clear <= 1'b0;
      end else begin
         ack           <= access;
         hold_release  <= rd_data && held;  // frees the holding register
         overrun_clear <= rd_status;
      end
   end

   // read data sampled in the access cycle
   always_ff @(posedge clock) begin
      if (access) begin
         dat_q <= read_value;
      end
   end

   assign wb_rsp.ack = ack;
   assign wb_rsp.dat = dat_q;

endmodule

`default_nettype wire

//--- readout/rx_readdata_latch.sv
`default_nettype none

module rx_readdata_latch
   import hub_pkg::*;
(
   input  logic                       clock,
   input  logic                       reset,
   input  grant_t                     grant,
   input  rx_word_t [num_buses-1:0]   words,
   input  logic                       hold_release,
   output bus_mask_t                  clear,
   output logic                       held,
   output bus_idx_t                   held_bus,
   output rx_word_t                   held_word,
   output logic                       irq_can_rec
);

   // clear the granted slot at the same edge the word is taken
   always_comb begin
      clear = '0;
      if (grant.valid) begin
         clear = bus_mask_t'(1) << grant.bus;
      end
   end

   // holding register busy flag
   always_ff @(posedge clock) begin
      if (reset) begin
         held <= 1'b0;
      end else if (grant.valid) begin
         held <= 1'b1;
      end else if (hold_release) begin
         held <= 1'b0;  // host read the data register
      end
   end

   // selected word and its bus number
   always_ff @(posedge clock) begin
      if (grant.valid) begin
         held_word <= words[grant.bus];
         held_bus  <= grant.bus;
      end
   end

   // interrupt stays up while a message waits for the host
   assign irq_can_rec = held;

endmodule

`default_nettype wire

//--- readout/rx_pending_decoder.sv
`default_nettype none

module rx_pending_decoder
   import hub_pkg::*;
(
   input  logic      clock,
   input  logic      reset,
   input  bus_mask_t pending,
   input  logic      held,
   output grant_t    grant
);

   scan_state_t state;
   bus_idx_t    last_bus;   // last granted bus, also the grant index
   bus_idx_t    next_pick;

   // first pending bus at or after start, wrapping past the top
   function automatic bus_idx_t next_bus(bus_mask_t mask, bus_idx_t start);
      bus_idx_t idx;
      bus_idx_t pick;
      logic     found;
      pick  = start;
      found = 1'b0;
      for (int i = 0; i < num_buses; i++) begin
         idx = bus_idx_t'(start + bus_idx_t'(i));
         if (!found && mask[idx]) begin
            pick  = idx;
            found = 1'b1;
         end
      end
      return pick;
   endfunction

   assign next_pick = next_bus(pending, bus_idx_t'(last_bus + 1'b1));

   always_ff @(posedge clock) begin
      if (reset) begin
         state    <= scan_idle;
         last_bus <= bus_idx_t'(num_buses - 1);  // search starts at bus 0
      end else begin
         case (state)
            scan_idle: begin
               if (!held && |pending) begin
                  last_bus <= next_pick;
                  state    <= scan_grant;
               end
            end
            scan_grant: state <= scan_wait;  // single grant cycle
            scan_wait:  if (held) state <= scan_idle;  // latch took the word
            default:    state <= scan_idle;
         endcase
      end
   end

   assign grant.valid = (state == scan_grant);
   assign grant.bus   = last_bus;

endmodule

`default_nettype wire

//--- src/rx_buffer_bank.sv
`default_nettype none

module rx_buffer_bank
   import hub_pkg::*;
(
   input  logic                       clock,
   input  logic                       reset,
   input  rx_write_t                  rx_write,
   input  bus_mask_t                  clear,
   input  logic                       overrun_clear,
   output bus_mask_t                  pending,
   output rx_word_t [num_buses-1:0]   words,
   output logic                       overrun
);

   bus_mask_t write_mask;
   logic      slot_busy;

   // one-hot of the slot being written this cycle
   assign write_mask = rx_write.strobe ? (bus_mask_t'(1) << rx_write.bus) : '0;

   // a slot still pending and not taken by the latch this cycle
   assign slot_busy = pending[rx_write.bus] && !clear[rx_write.bus];

   // word storage, one slot per bus
   always_ff @(posedge clock) begin
      if (rx_write.strobe) begin
         words[rx_write.bus] <= rx_write.data;
      end
   end

   // pending flags, write wins over clear on the same slot
   always_ff @(posedge clock) begin
      if (reset) begin
         pending <= '0;
      end else begin
         pending <= (pending & ~clear) | write_mask;
      end
   end

   // sticky overrun, a new overrun beats the host clear
   always_ff @(posedge clock) begin
      if (reset) begin
         overrun <= 1'b0;
      end else if (rx_write.strobe && slot_busy) begin
         overrun <= 1'b1;  // unread word replaced
      end else if (overrun_clear) begin
         overrun <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- common/wb_pkg.sv
`default_nettype none

package wb_pkg;

   typedef logic [1:0] wb_adr_t;
   typedef logic [15:0] wb_dat_t;

   typedef struct packed {
      logic    cyc;
      logic    stb;
      logic    we;
      wb_adr_t adr;
      wb_dat_t dat;
   } wb_req_t;

   typedef struct packed {
      logic    ack;
      wb_dat_t dat;
   } wb_rsp_t;

   localparam wb_adr_t addr_status = 2'd0;  // held, overrun, bus number
   localparam wb_adr_t addr_data   = 2'd1;  // held word, read ends the transfer

endpackage

`default_nettype wire

//--- common/hub_pkg.sv
`default_nettype none

package hub_pkg;

   localparam int num_buses = 32;  // CAN receivers on the hub

   typedef logic [$clog2(num_buses)-1:0] bus_idx_t;
   typedef logic [15:0] rx_word_t;
   typedef logic [num_buses-1:0] bus_mask_t;  // one bit per bus

   // decoder scan FSM
   typedef enum logic [1:0] {
      scan_idle,
      scan_grant,
      scan_wait
   } scan_state_t;

   // CAN side write into the buffer bank
   typedef struct packed {
      logic     strobe;
      bus_idx_t bus;
      rx_word_t data;
   } rx_write_t;

   // decoder to latch, valid for one cycle
   typedef struct packed {
      logic     valid;
      bus_idx_t bus;
   } grant_t;

endpackage

`default_nettype wire
